/* common/core_params.svh */
/* Fixed sizes of the RV32I pipeline core.
   Included by the package and by every RTL file. */

`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// Data and instruction width
`define XLEN 32

// Architectural registers, x0 included
`define REG_COUNT 32

// Byte address of the first fetch after reset
`define RESET_PC 0

`endif

/* common/rvPkg.sv */
/* Types shared by the pipeline stages: words, opcodes, ALU operations
   and the bundles that travel between stages. */

`include "core_params.svh"

package rvPkg;

        typedef logic [`XLEN-1:0] wordT;
        typedef logic [$clog2(`REG_COUNT)-1:0] regAddrT;
        typedef logic [2:0] funct3T;

        // Major opcodes of the supported subset
        typedef enum logic [6:0] {
                opOp     = 7'b0110011,
                opOpImm  = 7'b0010011,
                opLui    = 7'b0110111,
                opBranch = 7'b1100011
        } opcodeE;

        typedef enum logic [3:0] {
                aluAdd,
                aluSub,
                aluAnd,
                aluOr,
                aluXor,
                aluSlt,
                aluSltu,
                aluSll,
                aluSrl,
                aluSra,
                aluPassB
        } aluOpE;

        // Fetch to decode
        typedef struct packed {
                logic valid;
                wordT pc;
                wordT instr;
        } fetchBundleT;

        // Decode to execute
        typedef struct packed {
                logic    valid;
                wordT    pc;
                regAddrT rd;
                regAddrT rs1;
                regAddrT rs2;
                wordT    rs1Data;
                wordT    rs2Data;
                wordT    imm;
                logic    useImm;
                aluOpE   aluOp;
                logic    writesRd;
                logic    isBranch;
                funct3T  branchFunct;
        } decodeBundleT;

        // Register write that leaves execute, also the retire port
        typedef struct packed {
                logic    valid;
                wordT    pc;
                regAddrT rd;
                wordT    data;
        } retireT;

endpackage

/* design/core/fetchStage.sv */
/* Program counter and fetch/decode pipeline register.
   A redirect loads the branch target and squashes the word being fetched. */

`timescale 1ns/1ps
`include "core_params.svh"

module fetchStage import rvPkg::*; (
        input  logic        clk,
        input  logic        rst,
        input  logic        redirectValid,
        input  wordT        redirectPc,
        input  wordT        imemData,
        output wordT        imemAddr,
        output fetchBundleT fetchOut
);

        wordT pc;
        wordT nextPc;
        logic validQ;
        wordT pcQ;
        wordT instrQ;

        assign nextPc = redirectValid ? redirectPc : pc + wordT'(4);

        // Memory answers in the same cycle
        assign imemAddr = pc;

        always_ff @(posedge clk or posedge rst) begin
                if (rst) begin
                        pc <= wordT'(`RESET_PC);
                        validQ <= 1'b0;
                end else begin
                        pc <= nextPc;
                        validQ <= !redirectValid;
                end
        end

        // Fetched word and its address
        always_ff @(posedge clk) begin
                pcQ <= pc;
                instrQ <= imemData;
        end

        assign fetchOut = '{valid: validQ, pc: pcQ, instr: instrQ};

endmodule

/* design/core/decodeStage.sv */
/* Instruction decode and the decode/execute pipeline register.
   Builds immediates and ALU controls; unsupported encodings leave as bubbles. */

`timescale 1ns/1ps
`include "core_params.svh"

module decodeStage import rvPkg::*; (
        input  logic         clk,
        input  logic         rst,
        input  logic         flush,
        input  fetchBundleT  fetchIn,
        output regAddrT      rs1Addr,
        output regAddrT      rs2Addr,
        input  wordT         rs1Data,
        input  wordT         rs2Data,
        output decodeBundleT decodeOut
);

        opcodeE opcode;
        funct3T funct3;
        logic   alt;
        wordT   immI;
        wordT   immU;
        wordT   immB;
        logic   legal;
        aluOpE  funct3Op;

        decodeBundleT decodeNext;
        decodeBundleT bundleQ;
        logic         validQ;

        // Instruction fields
        assign opcode = opcodeE'(fetchIn.instr[6:0]);
        assign funct3 = fetchIn.instr[14:12];
        assign alt = fetchIn.instr[30];
        assign rs1Addr = fetchIn.instr[19:15];
        assign rs2Addr = fetchIn.instr[24:20];

        assign immI = {{(`XLEN-12){fetchIn.instr[31]}}, fetchIn.instr[31:20]};
        assign immU = {fetchIn.instr[31:12], 12'b0};
        assign immB = {{(`XLEN-12){fetchIn.instr[31]}}, fetchIn.instr[7],
                       fetchIn.instr[30:25], fetchIn.instr[11:8], 1'b0};

        // Shared by OP and OP-IMM; subtract only exists in OP
        always_comb begin
                unique case (funct3)
                        3'b000:  funct3Op = (alt && opcode == opOp) ? aluSub : aluAdd;
                        3'b001:  funct3Op = aluSll;
                        3'b010:  funct3Op = aluSlt;
                        3'b011:  funct3Op = aluSltu;
                        3'b100:  funct3Op = aluXor;
                        3'b101:  funct3Op = alt ? aluSra : aluSrl;
                        3'b110:  funct3Op = aluOr;
                        default: funct3Op = aluAnd;
                endcase
        end

        always_comb begin
                legal = 1'b1;
                decodeNext.pc = fetchIn.pc;
                decodeNext.rd = fetchIn.instr[11:7];
                decodeNext.rs1 = rs1Addr;
                decodeNext.rs2 = rs2Addr;
                decodeNext.rs1Data = rs1Data;
                decodeNext.rs2Data = rs2Data;
                decodeNext.imm = immI;
                decodeNext.useImm = 1'b0;
                decodeNext.aluOp = funct3Op;
                decodeNext.writesRd = 1'b0;
                decodeNext.isBranch = 1'b0;
                decodeNext.branchFunct = funct3;

                case (opcode)
                        opOp: begin
                                decodeNext.writesRd = 1'b1;
                        end
                        opOpImm: begin
                                decodeNext.useImm = 1'b1;
                                decodeNext.writesRd = 1'b1;
                        end
                        opLui: begin
                                decodeNext.imm = immU;
                                decodeNext.useImm = 1'b1;
                                decodeNext.aluOp = aluPassB;
                                decodeNext.writesRd = 1'b1;
                        end
                        opBranch: begin
                                decodeNext.imm = immB;
                                decodeNext.isBranch = 1'b1;
                                // BEQ, BNE, BLT and BGE only
                                legal = (funct3 == 3'b000) || (funct3 == 3'b001) ||
                                        (funct3 == 3'b100) || (funct3 == 3'b101);
                        end
                        default: begin
                                legal = 1'b0;
                        end
                endcase

                decodeNext.valid = fetchIn.valid && legal && !flush;
        end

        always_ff @(posedge clk or posedge rst) begin
                if (rst) begin
                        validQ <= 1'b0;
                end else begin
                        validQ <= decodeNext.valid;
                end
        end

        always_ff @(posedge clk) begin
                bundleQ <= decodeNext;
        end

        // Valid comes from the reset flop
        always_comb begin
                decodeOut = bundleQ;
                decodeOut.valid = validQ;
        end

endmodule

/* design/core/registerFile.sv */
/* Integer register file with two combinational read ports.
   A read of the register being written returns the new value. */

`timescale 1ns/1ps
`include "core_params.svh"

module registerFile import rvPkg::*; (
        input  logic    clk,
        input  logic    rst,
        input  regAddrT rs1Addr,
        input  regAddrT rs2Addr,
        output wordT    rs1Data,
        output wordT    rs2Data,
        input  retireT  writePort
);

        wordT regs [`REG_COUNT];

        // x0 first, then the write in flight, then the array
        function automatic wordT readReg(input regAddrT addr);
                if (addr == '0)
                        return '0;
                else if (writePort.valid && writePort.rd == addr)
                        return writePort.data;
                else
                        return regs[addr];
        endfunction

        always_ff @(posedge clk or posedge rst) begin
                if (rst) begin
                        for (int i = 0; i < `REG_COUNT; i++)
                                regs[i] <= '0;
                end else if (writePort.valid) begin
                        regs[writePort.rd] <= writePort.data;
                end
        end

        assign rs1Data = readReg(rs1Addr);
        assign rs2Data = readReg(rs2Addr);

endmodule

/* design/core/executeStage.sv */
/* Execute stage: forwarding from retire, ALU, branch resolution and the
   execute/writeback register whose output is the retire port. */

`timescale 1ns/1ps
`include "core_params.svh"

module executeStage import rvPkg::*; (
        input  logic         clk,
        input  logic         rst,
        input  decodeBundleT decodeIn,
        output logic         redirectValid,
        output wordT         redirectPc,
        output retireT       retire
);

        localparam int ShiftBits = $clog2(`XLEN);

        wordT opA;
        wordT opRs2;
        wordT opB;
        wordT aluResult;
        logic [ShiftBits-1:0] shamt;
        logic isEqual;
        logic isLess;
        logic taken;

        retireT retireNext;
        retireT retireQ;
        logic   validQ;

        // Retire never carries x0, so no zero check here
        assign opA = (retire.valid && retire.rd == decodeIn.rs1) ?
                     retire.data : decodeIn.rs1Data;
        assign opRs2 = (retire.valid && retire.rd == decodeIn.rs2) ?
                       retire.data : decodeIn.rs2Data;
        assign opB = decodeIn.useImm ? decodeIn.imm : opRs2;
        assign shamt = opB[ShiftBits-1:0];

        always_comb begin
                unique case (decodeIn.aluOp)
                        aluAdd:   aluResult = opA + opB;
                        aluSub:   aluResult = opA - opB;
                        aluAnd:   aluResult = opA & opB;
                        aluOr:    aluResult = opA | opB;
                        aluXor:   aluResult = opA ^ opB;
                        aluSlt:   aluResult = wordT'($signed(opA) < $signed(opB));
                        aluSltu:  aluResult = wordT'(opA < opB);
                        aluSll:   aluResult = opA << shamt;
                        aluSrl:   aluResult = opA >> shamt;
                        aluSra:   aluResult = wordT'($signed(opA) >>> shamt);
                        default:  aluResult = opB;
                endcase
        end

        // Branch compare on the forwarded register values
        assign isEqual = (opA == opRs2);
        assign isLess = ($signed(opA) < $signed(opRs2));

        always_comb begin
                unique case (decodeIn.branchFunct)
                        3'b000:  taken = isEqual;
                        3'b001:  taken = !isEqual;
                        3'b100:  taken = isLess;
                        default: taken = !isLess;
                endcase
        end

        assign redirectValid = decodeIn.valid && decodeIn.isBranch && taken;
        assign redirectPc = decodeIn.pc + decodeIn.imm;

        always_comb begin
                retireNext.valid = decodeIn.valid && decodeIn.writesRd &&
                                   decodeIn.rd != '0;
                retireNext.pc = decodeIn.pc;
                retireNext.rd = decodeIn.rd;
                retireNext.data = aluResult;
        end

        always_ff @(posedge clk or posedge rst) begin
                if (rst) begin
                        validQ <= 1'b0;
                end else begin
                        validQ <= retireNext.valid;
                end
        end

        always_ff @(posedge clk) begin
                retireQ <= retireNext;
        end

        always_comb begin
                retire = retireQ;
                retire.valid = validQ;
        end

endmodule

/* design/core/coreTop.sv */
/* Four-stage RV32I integer core. Fetches from an external combinational
   instruction memory and reports every register write on the retire port. */

`timescale 1ns/1ps
`include "core_params.svh"

module coreTop import rvPkg::*; (
        input  logic   clk,
        input  logic   rst,
        output wordT   imemAddr,
        input  wordT   imemData,
        output retireT retire
);

        fetchBundleT  fetchBus;
        decodeBundleT decodeBus;

        // Register file read side
        regAddrT rs1Addr;
        regAddrT rs2Addr;
        wordT    rs1Data;
        wordT    rs2Data;

        // Taken branch from execute
        logic redirectValid;
        wordT redirectPc;

        fetchStage u_fetchStage (
                .clk           (clk),
                .rst           (rst),
                .redirectValid (redirectValid),
                .redirectPc    (redirectPc),
                .imemData      (imemData),
                .imemAddr      (imemAddr),
                .fetchOut      (fetchBus)
        );

        decodeStage u_decodeStage (
                .clk       (clk),
                .rst       (rst),
                .flush     (redirectValid),
                .fetchIn   (fetchBus),
                .rs1Addr   (rs1Addr),
                .rs2Addr   (rs2Addr),
                .rs1Data   (rs1Data),
                .rs2Data   (rs2Data),
                .decodeOut (decodeBus)
        );

        // Write port fed straight from the retire bundle
        registerFile u_registerFile (
                .clk       (clk),
                .rst       (rst),
                .rs1Addr   (rs1Addr),
                .rs2Addr   (rs2Addr),
                .rs1Data   (rs1Data),
                .rs2Data   (rs2Data),
                .writePort (retire)
        );

        executeStage u_executeStage (
                .clk           (clk),
                .rst           (rst),
                .decodeIn      (decodeBus),
                .redirectValid (redirectValid),
                .redirectPc    (redirectPc),
                .retire        (retire)
        );

endmodule

/* testbench/tbClock.sv */
/* Clock and reset source for the core testbench.
   Reset is held at start and again each time restart rises. */

`timescale 1ns/1ps

module tbClock (
        input  logic restart,
        output logic clk,
        output logic rst
);

        localparam int HalfPeriod = 20;
        localparam int ResetCycles = 10;

        initial clk = 1'b0;

        always #HalfPeriod clk = ~clk;

        // Reset drops on a falling edge, away from the sampling edge
        always begin
                rst = 1'b1;
                repeat (ResetCycles) @(negedge clk);
                rst = 1'b0;
                @(posedge restart);
        end

endmodule

/* testbench/coreTb.sv */
/* Testbench for the pipeline core. Builds programs, runs them on a reference
   ISA model and checks every retirement of the DUT in order. */

`timescale 1ns/1ps
`include "core_params.svh"

module coreTb import rvPkg::*; ();

        localparam int ClockPeriod = 40;
        localparam int MaxProg = 64;
        localparam wordT NopInstr = 32'h0000_0013;

        typedef retireT retireListT[$];

        logic   clk;
        logic   rst;
        logic   restart = 1'b0;
        wordT   imemAddr;
        wordT   imemData;
        retireT retire;

        wordT       prog [MaxProg];
        int         progLen = 0;
        retireListT expected;
        int         expIdx = 0;
        int         cycleCount = 0;
        string      testName = "none";
        logic       running = 1'b0;
        time        deadline = 0;
        int         valueErrors = 0;
        int         protocolErrors = 0;
        int         timeoutErrors = 0;
        int         testsRun = 0;

        tbClock u_tbClock (
                .restart (restart),
                .clk     (clk),
                .rst     (rst)
        );

        coreTop u_coreTop (
                .clk      (clk),
                .rst      (rst),
                .imemAddr (imemAddr),
                .imemData (imemData),
                .retire   (retire)
        );

        // Combinational memory, NOP past the end
        assign imemData = (imemAddr < wordT'(progLen * 4)) ? prog[imemAddr[7:2]] : NopInstr;

        function automatic wordT encodeR(input logic [6:0] f7, input regAddrT rs2,
                                         input regAddrT rs1, input logic [2:0] f3,
                                         input regAddrT rd);
                return {f7, rs2, rs1, f3, rd, 7'b0110011};
        endfunction

        function automatic wordT encodeI(input logic [11:0] imm, input regAddrT rs1,
                                         input logic [2:0] f3, input regAddrT rd);
                return {imm, rs1, f3, rd, 7'b0010011};
        endfunction

        function automatic wordT encodeB(input logic [12:0] off, input regAddrT rs2,
                                         input regAddrT rs1, input logic [2:0] f3);
                return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
        endfunction

        // Random OP or OP-IMM, or the shift/compare/LUI mix
        function automatic wordT randomAlu(input logic shiftMix, input int rdMin,
                                           input int rdSpan);
                regAddrT rd;
                regAddrT rs1;
                regAddrT rs2;
                logic [2:0] f3;
                logic [1:0] pick;
                logic alt;
                logic [11:0] imm;
                rd = regAddrT'(rdMin + int'($urandom % rdSpan));
                rs1 = regAddrT'($urandom % 5);
                rs2 = regAddrT'($urandom % 5);
                pick = 2'($urandom);
                f3 = 3'($urandom);
                if (shiftMix) begin
                        if ($urandom % 5 == 0)
                                return {20'($urandom), rd, 7'b0110111};
                        f3 = (pick == 2'd0) ? 3'b001 : (pick == 2'd1) ? 3'b010 :
                             (pick == 2'd2) ? 3'b011 : 3'b101;
                end
                alt = (f3 == 3'b000 || f3 == 3'b101) && ($urandom % 2 == 1);
                if ($urandom % 2 == 0)
                        return encodeR(alt ? 7'h20 : 7'h00, rs2, rs1, f3, rd);
                if (f3 == 3'b001 || f3 == 3'b101)
                        imm = {(f3 == 3'b101 && alt) ? 7'h20 : 7'h00, 5'($urandom)};
                else
                        imm = 12'($urandom);
                return encodeI(imm, rs1, f3, rd);
        endfunction

        // RV32I arithmetic by funct3, alt selects SUB and SRA
        function automatic wordT computeAlu(input logic [2:0] f3, input logic alt,
                                            input wordT a, input wordT b);
                case (f3)
                        3'b000:  return alt ? a - b : a + b;
                        3'b001:  return a << b[4:0];
                        3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        3'b011:  return (a < b) ? 32'd1 : 32'd0;
                        3'b100:  return a ^ b;
                        3'b101:  return alt ? wordT'($signed(a) >>> b[4:0]) : a >> b[4:0];
                        3'b110:  return a | b;
                        default: return a & b;
                endcase
        endfunction

        // Instruction-set model of the loaded program
        function automatic retireListT refRun();
                wordT regs [`REG_COUNT];
                wordT pc;
                wordT nextPc;
                wordT instr;
                wordT a;
                wordT b;
                wordT immB;
                wordT result;
                logic writes;
                logic taken;
                retireT entry;
                retireListT list;
                int steps;
                for (int i = 0; i < `REG_COUNT; i++)
                        regs[i] = '0;
                pc = wordT'(`RESET_PC);
                steps = 0;
                // Branches only go forward, so leaving the program ends the run
                while (pc < wordT'(progLen * 4) && steps < 4 * MaxProg) begin
                        instr = prog[pc[7:2]];
                        a = regs[instr[19:15]];
                        b = regs[instr[24:20]];
                        nextPc = pc + 32'd4;
                        writes = 1'b1;
                        result = '0;
                        case (instr[6:0])
                                7'b0110011: result = computeAlu(instr[14:12], instr[30], a, b);
                                // Only the right shift honours bit 30 here
                                7'b0010011: result = computeAlu(instr[14:12],
                                        instr[30] && instr[14:12] == 3'b101, a,
                                        {{20{instr[31]}}, instr[31:20]});
                                7'b0110111: result = {instr[31:12], 12'b0};
                                7'b1100011: begin
                                        writes = 1'b0;
                                        immB = {{20{instr[31]}}, instr[7], instr[30:25],
                                                instr[11:8], 1'b0};
                                        case (instr[14:12])
                                                3'b000:  taken = (a == b);
                                                3'b001:  taken = (a != b);
                                                3'b100:  taken = ($signed(a) < $signed(b));
                                                3'b101:  taken = ($signed(a) >= $signed(b));
                                                default: taken = 1'b0;
                                        endcase
                                        if (taken)
                                                nextPc = pc + immB;
                                end
                                default: writes = 1'b0;
                        endcase
                        if (writes && instr[11:7] != 5'd0) begin
                                regs[instr[11:7]] = result;
                                entry.valid = 1'b1;
                                entry.pc = pc;
                                entry.rd = instr[11:7];
                                entry.data = result;
                                list.push_back(entry);
                        end
                        pc = nextPc;
                        steps++;
                end
                return list;
        endfunction

        task automatic addInstr(input wordT instr);
                prog[progLen[5:0]] = instr;
                progLen++;
        endtask

        // Puts the DUT back in reset, then the program can be rebuilt
        task automatic beginTest(input string name);
                testName = name;
                restart = 1'b1;
                @(negedge clk);
                restart = 1'b0;
                progLen = 0;
        endtask

        task automatic runProgram();
                expected = refRun();
                testsRun++;
                @(negedge rst);
                deadline = $time + time'((progLen + 20) * ClockPeriod);
                running = 1'b1;
                while (expIdx < expected.size())
                        @(negedge clk);
                // A few more cycles to catch late extra retirements
                repeat (5) @(negedge clk);
                running = 1'b0;
        endtask

        task automatic reportValue(input string what, input wordT expVal, input wordT actVal);
                valueErrors++;
                $display("** Error [%s] %s: expected %h, actual %h", testName, what, expVal, actVal);
        endtask

        task automatic finishRun();
                $display("Tests %0d, value errors %0d, protocol errors %0d, timeouts %0d",
                         testsRun, valueErrors, protocolErrors, timeoutErrors);
                if (valueErrors + protocolErrors + timeoutErrors == 0)
                        $display("*** PASSED ***");
                else
                        $display("*** FAILED ***");
                $finish;
        endtask

        always @(posedge clk) begin : compareRetire
                retireT entry;
                if (rst) begin
                        cycleCount = 0;
                        expIdx = 0;
                        assert (!retire.valid) else begin
                                protocolErrors++;
                                $display("Retire valid while reset is held in test %s", testName);
                        end
                end else begin
                        cycleCount++;
                        if (cycleCount == 1) begin
                                assert (imemAddr == wordT'(`RESET_PC)) else
                                        reportValue("first fetch address", wordT'(`RESET_PC), imemAddr);
                        end
                        if (retire.valid) begin
                                assert (expIdx < expected.size()) else begin
                                        protocolErrors++;
                                        $display("Extra retirement in test %s at pc %h, rd x%0d",
                                                 testName, retire.pc, retire.rd);
                                end
                                if (expIdx < expected.size()) begin
                                        entry = expected[expIdx];
                                        // PC 0 fetched in cycle 1 retires in cycle 4
                                        if (expIdx == 0 && entry.pc == wordT'(`RESET_PC)) begin
                                                assert (cycleCount == 4) else
                                                        reportValue("first retire cycle", 32'd4,
                                                                    wordT'(cycleCount));
                                        end
                                        assert (retire.pc == entry.pc) else
                                                reportValue("retire pc", entry.pc, retire.pc);
                                        assert (retire.rd == entry.rd) else
                                                reportValue("retire rd", wordT'(entry.rd),
                                                            wordT'(retire.rd));
                                        assert (retire.data == entry.data) else
                                                reportValue("retire data", entry.data, retire.data);
                                        expIdx++;
                                end
                        end
                end
        end

        initial begin : watchdog
                @(negedge clk);
                while (!(running && $time > deadline))
                        @(negedge clk);
                timeoutErrors++;
                $display("Timeout in test %s: only %0d of %0d expected retirements seen",
                         testName, expIdx, expected.size());
                finishRun();
        end

        initial begin : mainSequence
                int k;
                logic [1:0] pick;
                void'($urandom(74495));

                beginTest("reset");
                addInstr(encodeI(12'd5, 5'd0, 3'b000, 5'd1));
                addInstr(encodeI(12'd3, 5'd1, 3'b000, 5'd2));
                addInstr(encodeR(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
                runProgram();

                // Few registers, so dependencies are close together
                beginTest("arith");
                repeat (48) addInstr(randomAlu(1'b0, 1, 4));
                runProgram();

                beginTest("shift");
                repeat (48) addInstr(randomAlu(1'b1, 1, 4));
                runProgram();

                // Small operands make equal and negative compares common
                beginTest("branch");
                repeat (10) begin
                        addInstr(encodeI(12'(int'($urandom % 3) - 1), 5'd0, 3'b000, 5'd1));
                        addInstr(encodeI(12'(int'($urandom % 3) - 1), 5'd0, 3'b000, 5'd2));
                        k = 3 + int'($urandom % 2);
                        pick = 2'($urandom);
                        addInstr(encodeB(13'(k * 4), 5'd2, 5'd1, {pick[1], 1'b0, pick[0]}));
                        repeat (k - 1) addInstr(encodeI(12'd1, 5'd3, 3'b000, 5'd3));
                end
                addInstr(encodeI(12'd0, 5'd3, 3'b000, 5'd4));
                runProgram();

                beginTest("x0");
                addInstr(encodeI(12'h055, 5'd0, 3'b000, 5'd0));
                addInstr(encodeR(7'h00, 5'd0, 5'd0, 3'b000, 5'd1));
                repeat (40) addInstr(randomAlu(1'b0, 0, 2));
                runProgram();

                finishRun();
        end

endmodule

/* sim.f */
+incdir+common
common/rvPkg.sv
design/core/fetchStage.sv
design/core/decodeStage.sv
design/core/registerFile.sv
design/core/executeStage.sv
design/core/coreTop.sv
testbench/tbClock.sv
testbench/coreTb.sv

/* run.sh */
#!/bin/sh
# Builds the core testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module coreTb -o coreSim

output=$(./obj_dir/coreSim)
echo "$output"

# Fails the script unless the pass message was printed
echo "$output" | grep -qF '*** PASSED ***'
